// File: build.f
vote_pkg.sv
vote_lfsr.sv
vote_counter.sv
vote_sequencer.sv
vote_apb_regs.sv
vote_top.sv
tb_vote_top.sv

// File: run.sh
#!/bin/sh
# build the vote combiner testbench with Verilator and run it
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_vote_top -o tb_vote_top -f build.f \
    && ./obj_dir/tb_vote_top | tee /dev/stderr | grep -q "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb_vote_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vote_top;

    // worst case per bit is 255 rounds with 4-cycle gaps, plus clear and store
    localparam int timeout_cycles = 4 * 32 * (255 * 4 + 3) + 5000;
    localparam int rand_seed      = 32'h4855_1251;

    // core stimulus styles
    localparam int mode_random = 0;
    localparam int mode_tie    = 1;
    localparam int mode_mask   = 2;

    logic                clk;
    logic                rst;
    vote_pkg::apb_addr_t paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    vote_pkg::word_t     pwdata;
    vote_pkg::word_t     prdata;
    logic                pready;
    logic                pslverr;
    vote_pkg::core_vec_t core_result;
    logic                core_valid;
    logic                core_ready;

    int              cycle_cnt;
    int              accepted;
    int              job_base;
    int              job_rounds;
    int              ready_hold;
    logic            job_active;
    logic            err;
    vote_pkg::word_t rd;

    vote_top uut (
        .clk         (clk),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .core_result (core_result),
        .core_valid  (core_valid),
        .core_ready  (core_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // rounds taken by the DUT on each accepting edge
    always @(posedge clk) begin
        if (rst) begin
            accepted <= 0;
        end else if (core_valid && core_ready) begin
            accepted <= accepted + 1;
        end
    end

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("ERROR at %0t: %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual == expected) else value_error(name, expected, actual);
    endtask

    // handshake is only open inside a running job
    assert property (@(posedge clk) disable iff (rst) !job_active |-> !core_ready)
        else value_error("core_ready", 32'h0, {31'h0, $sampled(core_ready)});
    assert property (@(posedge clk) rst |=> !core_ready)
        else value_error("core_ready", 32'h0, {31'h0, $sampled(core_ready)});
    assert property (@(posedge clk) disable iff (rst) pready)
        else value_error("pready", 32'h1, {31'h0, $sampled(pready)});

    // store and clear follow the last round of a bit with ready low
    always @(posedge clk) begin
        if (rst) begin
            ready_hold <= 0;
        end else if (core_valid && core_ready
                     && (accepted - job_base + 1) % job_rounds == 0) begin
            ready_hold <= 2;
        end else if (ready_hold != 0) begin
            assert (!core_ready) else value_error("core_ready", 32'h0, {31'h0, core_ready});
            ready_hold <= ready_hold - 1;
        end
    end

    // setup then access with the response taken on the completing edge
    task automatic apb_write(input vote_pkg::apb_addr_t addr, input vote_pkg::word_t data,
                             output logic slverr);
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        slverr = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input vote_pkg::apb_addr_t addr, output vote_pkg::word_t data,
                            output logic slverr);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        data   = prdata;
        slverr = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_expect(input vote_pkg::apb_addr_t addr, input vote_pkg::word_t data,
                                input logic exp_err);
        logic slverr;
        apb_write(addr, data, slverr);
        check_val("pslverr", {31'h0, exp_err}, {31'h0, slverr});
    endtask

    task automatic read_expect(input vote_pkg::apb_addr_t addr, input vote_pkg::word_t expected,
                               input string name);
        vote_pkg::word_t data;
        logic            slverr;
        apb_read(addr, data, slverr);
        check_val("pslverr", 32'h0, {31'h0, slverr});
        check_val(name, expected, data);
    endtask

    // reference lfsr as galois shift right with 0xB400 feedback
    function automatic vote_pkg::seed_t lfsr_advance(input vote_pkg::seed_t s);
        vote_pkg::seed_t n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // +1 per enabled one, -1 per enabled zero
    function automatic int core_votes(input vote_pkg::core_vec_t mask,
                                      input vote_pkg::core_vec_t vec);
        int v;
        v = 0;
        for (int i = 0; i < vote_pkg::n_cores; i++) begin
            if (mask[i]) begin
                v += vec[i] ? 1 : -1;
            end
        end
        return v;
    endfunction

    function automatic vote_pkg::core_vec_t make_round(input int mode);
        logic [31:0] r;
        r = $urandom;
        case (mode)
            // core0 and core1 cancel while the upper cores are noise
            mode_tie: return {r[1:0], 2'b01};
            // core0 alone against three disabled cores
            mode_mask: return r[0] ? 4'b0001 : 4'b1110;
            default: return r[3:0];
        endcase
    endfunction

    // ready only moves on the rising edge so it is stable here
    task automatic send_round(input vote_pkg::core_vec_t vec);
        int gap;
        gap = int'($urandom % 4);
        @(negedge clk);
        repeat (gap) @(negedge clk);
        core_result = vec;
        core_valid  = 1'b1;
        while (!core_ready) @(negedge clk);
        @(negedge clk);
        core_valid = 1'b0;
    endtask

    task automatic run_job(input vote_pkg::rounds_t rounds, input vote_pkg::core_vec_t mask,
                           input vote_pkg::seed_t seed, input int mode, input bit busy_writes);
        vote_pkg::seed_t lfsr;
        vote_pkg::word_t expected;
        vote_pkg::word_t tie_word;
        vote_pkg::word_t data;
        logic            slverr;
        int              sum;
        int              acc_start;
        write_expect(vote_pkg::addr_core_en, {28'h0, mask}, 1'b0);
        write_expect(vote_pkg::addr_seed, {16'h0, seed}, 1'b0);
        lfsr      = (seed == '0) ? 16'h0001 : seed;
        expected  = '0;
        tie_word  = '0;
        acc_start = accepted;
        job_base   = accepted;
        job_rounds = int'(rounds);
        job_active = 1'b1;
        write_expect(vote_pkg::addr_ctrl, {16'h0, rounds, 8'h01}, 1'b0);
        // valid is low so the job parks in collect
        do begin
            apb_read(vote_pkg::addr_status, data, slverr);
        end while (!data[0]);
        // done from the previous job is gone
        check_val("status", 32'h1, data);
        if (busy_writes) begin
            write_expect(vote_pkg::addr_ctrl, 32'h0000_0701, 1'b1);
            write_expect(vote_pkg::addr_core_en, 32'h0, 1'b1);
            write_expect(vote_pkg::addr_seed, 32'h0000_FFFF, 1'b1);
            read_expect(vote_pkg::addr_ctrl, {16'h0, rounds, 8'h00}, "ctrl");
            read_expect(vote_pkg::addr_core_en, {28'h0, mask}, "core_en");
            read_expect(vote_pkg::addr_seed, {16'h0, seed}, "seed");
        end
        for (int b = 0; b < vote_pkg::job_bits; b++) begin
            lfsr = lfsr_advance(lfsr);
            // even vote total gets the tie preload
            if ((int'(rounds) * $countones(mask)) % 2 == 0) begin
                sum = lfsr[0] ? -1 : 1;
            end else begin
                sum = 0;
            end
            for (int r = 0; r < int'(rounds); r++) begin
                core_result = make_round(mode);
                sum += core_votes(mask, core_result);
                send_round(core_result);
            end
            expected = expected | (vote_pkg::word_t'(sum > 0) << b);
            tie_word = tie_word | (vote_pkg::word_t'(lfsr[0]) << b);
        end
        do begin
            apb_read(vote_pkg::addr_status, data, slverr);
        end while (!data[1]);
        check_val("status", 32'h2, data);
        job_active = 1'b0;
        apb_read(vote_pkg::addr_result, data, slverr);
        check_val("result", expected, data);
        if (mode == mode_tie) begin
            check_val("result vs tie bits", ~tie_word, data);
        end
        check_val("accepted rounds", 32 * int'(rounds), accepted - acc_start);
        // valid left high after the job must stay unanswered
        @(negedge clk);
        core_valid = 1'b1;
        acc_start  = accepted;
        repeat (8) @(negedge clk);
        core_valid = 1'b0;
        check_val("accepted after job", 32'h0, accepted - acc_start);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
        $display("ERRORS FOUND");
        $fatal(1, "run limit reached");
    end

    initial begin
        rst         = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        core_result = '0;
        core_valid  = 1'b0;
        job_active  = 1'b0;
        job_base    = 0;
        job_rounds  = 1;
        void'($urandom(rand_seed));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_val("core_ready", 32'h0, {31'h0, core_ready});
        read_expect(vote_pkg::addr_ctrl, 32'h0, "ctrl");
        read_expect(vote_pkg::addr_core_en, 32'h0, "core_en");
        read_expect(vote_pkg::addr_seed, 32'h0, "seed");
        read_expect(vote_pkg::addr_status, 32'h0, "status");
        read_expect(vote_pkg::addr_result, 32'h0, "result");

        // only the low field bits are kept
        write_expect(vote_pkg::addr_core_en, 32'hFFFF_FFFA, 1'b0);
        read_expect(vote_pkg::addr_core_en, 32'hA, "core_en");
        write_expect(vote_pkg::addr_seed, 32'hABCD_5A5A, 1'b0);
        read_expect(vote_pkg::addr_seed, 32'h5A5A, "seed");
        write_expect(vote_pkg::addr_result, 32'hDEAD_BEEF, 1'b0);
        read_expect(vote_pkg::addr_result, 32'h0, "result");

        // unmapped offsets
        write_expect(8'h14, 32'h0000_0005, 1'b1);
        apb_read(8'h20, rd, err);
        check_val("pslverr", 32'h1, {31'h0, err});
        read_expect(vote_pkg::addr_core_en, 32'hA, "core_en");

        // start with zero rounds is refused and leaves rounds alone
        write_expect(vote_pkg::addr_ctrl, 32'h0000_0500, 1'b0);
        read_expect(vote_pkg::addr_ctrl, 32'h0000_0500, "ctrl");
        write_expect(vote_pkg::addr_ctrl, 32'h0000_0001, 1'b1);
        read_expect(vote_pkg::addr_ctrl, 32'h0000_0500, "ctrl");
        read_expect(vote_pkg::addr_status, 32'h0, "status");

        run_job(8'd3, 4'hF, 16'hACE1, mode_random, 1'b1);
        run_job(8'd2, 4'h3, 16'h5A3C, mode_tie, 1'b0);
        run_job(8'd2, 4'h3, 16'h0000, mode_tie, 1'b0);
        run_job(8'd3, 4'h1, 16'h0BAD, mode_mask, 1'b0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: vote_top.sv
`timescale 1ns/1ps
`default_nettype none

module vote_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire vote_pkg::apb_addr_t paddr,
    input  wire                      psel,
    input  wire                      penable,
    input  wire                      pwrite,
    input  wire vote_pkg::word_t     pwdata,
    output vote_pkg::word_t          prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  wire vote_pkg::core_vec_t core_result,
    input  wire                      core_valid,
    output logic                     core_ready
);

    // configuration from the register block
    logic                start;
    vote_pkg::rounds_t   rounds;
    vote_pkg::core_vec_t core_en;
    vote_pkg::seed_t     seed;

    // sequencer controls
    logic clear;
    logic update;
    logic load;
    logic step;

    // datapath feedback
    logic tie_bit;
    logic sign_bit;

    // job status and result
    logic            busy;
    logic            done;
    vote_pkg::word_t result_word;
    logic            result_we;

    vote_apb_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .busy        (busy),
        .done        (done),
        .result_word (result_word),
        .result_we   (result_we),
        .start       (start),
        .rounds      (rounds),
        .core_en     (core_en),
        .seed        (seed)
    );

    vote_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .rounds      (rounds),
        .core_valid  (core_valid),
        .sign_bit    (sign_bit),
        .core_ready  (core_ready),
        .clear       (clear),
        .update      (update),
        .load        (load),
        .step        (step),
        .busy        (busy),
        .done        (done),
        .result_word (result_word),
        .result_we   (result_we)
    );

    vote_counter u_counter (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .update      (update),
        .tie_bit     (tie_bit),
        .rounds      (rounds),
        .core_en     (core_en),
        .core_result (core_result),
        .sign_bit    (sign_bit)
    );

    vote_lfsr u_lfsr (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .step    (step),
        .seed    (seed),
        .tie_bit (tie_bit)
    );

endmodule

`default_nettype wire

// File: vote_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module vote_apb_regs (
    input  wire                      clk,
    input  wire                      rst,
    input  wire vote_pkg::apb_addr_t paddr,
    input  wire                      psel,
    input  wire                      penable,
    input  wire                      pwrite,
    input  wire vote_pkg::word_t     pwdata,
    output vote_pkg::word_t          prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  wire                      busy,
    input  wire                      done,
    input  wire vote_pkg::word_t     result_word,
    input  wire                      result_we,
    output logic                     start,
    output vote_pkg::rounds_t        rounds,
    output vote_pkg::core_vec_t      core_en,
    output vote_pkg::seed_t          seed
);

    vote_pkg::word_t result_q;
    logic            access;
    logic            sel_ctrl;
    logic            sel_core_en;
    logic            sel_seed;
    logic            sel_status;
    logic            sel_result;
    logic            mapped;
    logic            cfg_busy;
    logic            bad_start;
    logic            wr_ok;

    // no wait states
    assign pready = 1'b1;
    assign access = psel & penable;

    assign sel_ctrl    = (paddr == vote_pkg::addr_ctrl);
    assign sel_core_en = (paddr == vote_pkg::addr_core_en);
    assign sel_seed    = (paddr == vote_pkg::addr_seed);
    assign sel_status  = (paddr == vote_pkg::addr_status);
    assign sel_result  = (paddr == vote_pkg::addr_result);
    assign mapped = sel_ctrl | sel_core_en | sel_seed | sel_status | sel_result;

    // config frozen while a job runs, start included
    assign cfg_busy  = pwrite & busy & (sel_ctrl | sel_core_en | sel_seed);
    // start with zero rounds would never finish
    assign bad_start = pwrite & sel_ctrl & pwdata[0] & (pwdata[15:8] == 8'h00);

    assign pslverr = access & (~mapped | cfg_busy | bad_start);
    assign wr_ok   = access & pwrite & ~pslverr;

    always_ff @(posedge clk) begin
        if (rst) begin
            rounds  <= '0;
            core_en <= '0;
            seed    <= '0;
            start   <= 1'b0;
        end else begin
            // single-cycle pulse
            start <= wr_ok & sel_ctrl & pwdata[0];
            if (wr_ok & sel_ctrl) begin
                rounds <= pwdata[15:8];
            end
            if (wr_ok & sel_core_en) begin
                core_en <= pwdata[vote_pkg::n_cores-1:0];
            end
            if (wr_ok & sel_seed) begin
                seed <= pwdata[vote_pkg::lfsr_w-1:0];
            end
        end
    end

    // result is read-only from the bus side
    always_ff @(posedge clk) begin
        if (rst) begin
            result_q <= '0;
        end else if (result_we) begin
            result_q <= result_word;
        end
    end

    // read mux, start bit reads back as zero
    always_comb begin
        prdata = '0;
        if (sel_ctrl) begin
            prdata[15:8] = rounds;
        end else if (sel_core_en) begin
            prdata[vote_pkg::n_cores-1:0] = core_en;
        end else if (sel_seed) begin
            prdata[vote_pkg::lfsr_w-1:0] = seed;
        end else if (sel_status) begin
            prdata[1:0] = {done, busy};
        end else if (sel_result) begin
            prdata = result_q;
        end
    end

endmodule

`default_nettype wire

// File: vote_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module vote_sequencer (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  start,
    input  wire vote_pkg::rounds_t rounds,
    input  wire                  core_valid,
    input  wire                  sign_bit,
    output logic                 core_ready,
    output logic                 clear,
    output logic                 update,
    output logic                 load,
    output logic                 step,
    output logic                 busy,
    output logic                 done,
    output vote_pkg::word_t      result_word,
    output logic                 result_we
);

    vote_pkg::seq_state_t state;
    vote_pkg::rounds_t    round_cnt;
    vote_pkg::bit_idx_t   bit_idx;
    vote_pkg::word_t      result_q;
    vote_pkg::word_t      result_next;
    logic                 last_round;
    logic                 last_bit;

    // handshake only open while collecting
    assign core_ready = (state == vote_pkg::collect);
    assign update     = core_ready & core_valid;

    // one preload and one lfsr advance per output bit
    assign clear = (state == vote_pkg::clear);
    assign step  = clear;

    // seed goes in as the job leaves idle
    assign load = (state == vote_pkg::idle) & start;

    assign busy      = (state != vote_pkg::idle);
    assign result_we = (state == vote_pkg::store);

    assign last_round = (round_cnt == rounds - vote_pkg::rounds_t'(1));
    assign last_bit   = (bit_idx == vote_pkg::bit_idx_t'(vote_pkg::job_bits - 1));

    // majority bit merged in so the store edge sees the full word
    always_comb begin
        result_next = result_q;
        result_next[bit_idx] = ~sign_bit;
    end

    assign result_word = result_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= vote_pkg::idle;
            round_cnt <= '0;
            bit_idx   <= '0;
            done      <= 1'b0;
        end else begin
            case (state)
                vote_pkg::idle: begin
                    if (start) begin
                        state   <= vote_pkg::clear;
                        bit_idx <= '0;
                        done    <= 1'b0;
                    end
                end
                vote_pkg::clear: begin
                    round_cnt <= '0;
                    state     <= vote_pkg::collect;
                end
                vote_pkg::collect: begin
                    // edge accepting the last round ends collect
                    if (update) begin
                        if (last_round) begin
                            state <= vote_pkg::store;
                        end else begin
                            round_cnt <= round_cnt + vote_pkg::rounds_t'(1);
                        end
                    end
                end
                vote_pkg::store: begin
                    bit_idx <= bit_idx + vote_pkg::bit_idx_t'(1);
                    if (last_bit) begin
                        state <= vote_pkg::idle;
                        done  <= 1'b1;
                    end else begin
                        state <= vote_pkg::clear;
                    end
                end
                default: begin
                    state <= vote_pkg::idle;
                end
            endcase
        end
    end

    // result bits, wiped at job start
    always_ff @(posedge clk) begin
        if (rst) begin
            result_q <= '0;
        end else if (load) begin
            result_q <= '0;
        end else if (result_we) begin
            result_q <= result_next;
        end
    end

endmodule

`default_nettype wire

// File: vote_counter.sv
`timescale 1ns/1ps
`default_nettype none

module vote_counter (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    clear,
    input  wire                    update,
    input  wire                    tie_bit,
    input  wire vote_pkg::rounds_t   rounds,
    input  wire vote_pkg::core_vec_t core_en,
    input  wire vote_pkg::core_vec_t core_result,
    output logic                   sign_bit
);

    vote_pkg::vote_sum_t sum;
    vote_pkg::vote_sum_t preload;
    vote_pkg::vote_sum_t delta;
    logic                odd_votes;

    // rounds x popcount is odd only if both factors are odd
    assign odd_votes = rounds[0] & (^core_en);

    // even count gets +1/-1 so the sum never lands on zero
    always_comb begin
        if (odd_votes) begin
            preload = '0;
        end else if (tie_bit) begin
            preload = '1;
        end else begin
            preload = vote_pkg::vote_sum_t'(1);
        end
    end

    // per-core select: +1 for a one, -1 for a zero, 0 when disabled
    always_comb begin
        delta = '0;
        for (int i = 0; i < vote_pkg::n_cores; i++) begin
            if (core_en[i]) begin
                if (core_result[i]) begin
                    delta = delta + vote_pkg::vote_sum_t'(1);
                end else begin
                    delta = delta - vote_pkg::vote_sum_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum <= '0;
        end else if (clear) begin
            sum <= preload;
        end else if (update) begin
            sum <= sum + delta;
        end
    end

    // negative sum means zeros won
    assign sign_bit = sum[vote_pkg::sum_w-1];

endmodule

`default_nettype wire

// File: vote_lfsr.sv
`timescale 1ns/1ps
`default_nettype none

module vote_lfsr (
    input  wire               clk,
    input  wire               rst,
    input  wire               load,
    input  wire               step,
    input  wire vote_pkg::seed_t seed,
    output logic              tie_bit
);

    vote_pkg::seed_t state;
    vote_pkg::seed_t state_next;

    // galois form, taps x^16+x^14+x^13+x^11
    always_comb begin
        state_next = state >> 1;
        if (state[0]) begin
            state_next = state_next ^ 16'hB400;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // zero until first load
            state <= '0;
        end else if (load) begin
            // all-zero state would lock up
            state <= (seed == '0) ? vote_pkg::seed_t'(1) : seed;
        end else if (step) begin
            state <= state_next;
        end
    end

    // taken from the advanced state so it is valid in the step cycle
    assign tie_bit = state_next[0];

endmodule

`default_nettype wire

// File: vote_pkg.sv
`default_nettype none

package vote_pkg;

    // ensemble size and job length
    localparam int n_cores  = 4;
    localparam int job_bits = 32;

    // counter covers 255 rounds x 4 cores plus the tie preload
    localparam int sum_w  = 12;
    localparam int lfsr_w = 16;

    // per-core result bits and enable mask
    typedef logic [n_cores-1:0] core_vec_t;
    typedef logic [7:0]         rounds_t;
    typedef logic [lfsr_w-1:0]  seed_t;
    // two's complement, read as signed
    typedef logic [sum_w-1:0]   vote_sum_t;
    typedef logic [4:0]         bit_idx_t;
    typedef logic [7:0]         apb_addr_t;
    typedef logic [31:0]        word_t;

    // register offsets
    localparam apb_addr_t addr_ctrl    = 8'h00;
    localparam apb_addr_t addr_core_en = 8'h04;
    localparam apb_addr_t addr_seed    = 8'h08;
    localparam apb_addr_t addr_status  = 8'h0C;
    localparam apb_addr_t addr_result  = 8'h10;

    // job sequencer states
    typedef enum logic [1:0] {
        idle,
        clear,
        collect,
        store
    } seq_state_t;

endpackage

`default_nettype wire
